// ==== Bender.yml ====
package:
  name: calculator

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/calc_pkg.sv
      - source/bcd_digit.sv
      - source/calc_stack.sv
      - source/key_entry.sv
      - source/infix_to_postfix.sv
      - source/postfix_eval.sv
      - source/bcd_convert.sv
      - source/result_format.sv
      - source/calculator_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/tb_calculator.sv

// ==== bench/tb_calculator.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module tb_calculator import calc_pkg::*;;

    typedef logic [`CALC_TEXT_LEN-1:0][7:0] line_t;

    localparam int NUM_RANDOM = 12;
    localparam int NUM_EXPR   = 10 + NUM_RANDOM;  // directed plus random
    localparam int MAX_CYCLES = 300 * NUM_EXPR;

    // key code is 10 plus the operator encoding
    localparam int OPC_ADD = 0;
    localparam int OPC_SUB = 1;
    localparam int OPC_MUL = 2;

    localparam logic [3:0] CODE_EQU    = 4'd13;
    localparam logic [3:0] CODE_UNUSED = 4'd14;

    logic      rst;
    logic      clk_100hz;
    logic      key_req;
    key_code_t key_code;
    logic      key_ack;
    logic      result_req;
    logic      result_ack;
    line_t     result_char;

    longint unsigned expr_val [0:4];
    int              expr_op [0:3];
    int              expr_n_ops;
    logic [31:0]     rng;
    int              cycles;
    int              value_errors;
    int              protocol_errors;

    calculator_top dut0 (
        .rst         (rst),
        .clk_100hz   (clk_100hz),
        .key_req     (key_req),
        .key_code    (key_code),
        .key_ack     (key_ack),
        .result_req  (result_req),
        .result_ack  (result_ack),
        .result_char (result_char)
    );

    initial
    begin
        rst = 1'b0;
        forever #50 rst = ~rst;
    end

    always @(posedge rst)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: no response after %0d cycles", cycles);
            $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // sum of products that wraps at 32 bits
    function automatic logic [31:0] eval_model();
        logic [31:0] sum;
        logic [31:0] term;
        int          pend;
        sum  = '0;
        pend = OPC_ADD;
        term = expr_val[0][31:0];
        for (int i = 0; i < expr_n_ops; i++)
        begin
            if (expr_op[i] == OPC_MUL)
                term = term * expr_val[i + 1][31:0];
            else
            begin
                sum  = (pend == OPC_SUB) ? sum - term : sum + term;
                pend = expr_op[i];
                term = expr_val[i + 1][31:0];
            end
        end
        return (pend == OPC_SUB) ? sum - term : sum + term;
    endfunction

    function automatic line_t format_line(input logic [31:0] v);
        line_t       l;
        logic [31:0] mag;
        int          i;
        for (i = 0; i < `CALC_TEXT_LEN; i++)
            l[i] = 8'h20;
        mag = v[31] ? (~v + 1'b1) : v;
        i   = 0;
        do
        begin
            l[i] = 8'h30 + 8'(mag % 10);  // ascii digit
            mag  = mag / 10;
            i++;
        end
        while (mag != 0);
        if (v[31])
            l[i] = 8'h2d;
        return l;
    endfunction

    task automatic press_key(input logic [3:0] code);
        @(posedge rst);
        key_code <= key_code_t'(code);
        key_req  <= 1'b1;
        do @(negedge rst); while (!key_ack);
        @(posedge rst);
        key_req <= 1'b0;
        do @(negedge rst); while (key_ack);
    endtask

    task automatic type_number(input longint unsigned n);
        logic [3:0]      digits [0:19];
        int              count;
        longint unsigned rest;
        rest  = n;
        count = 0;
        do
        begin
            digits[count] = 4'(rest % 10);
            rest = rest / 10;
            count++;
        end
        while (rest != 0);
        for (int i = count - 1; i >= 0; i--)
            press_key(digits[i]);  // msd first
    endtask

    task automatic enter_expression();
        type_number(expr_val[0]);
        for (int i = 0; i < expr_n_ops; i++)
        begin
            press_key(4'(10 + expr_op[i]));
            type_number(expr_val[i + 1]);
        end
        press_key(CODE_EQU);
    endtask

    task automatic expect_result(input line_t expected, input int ack_delay);
        line_t snap;
        if (ack_delay > 0)
        begin
            // an ignored key code waits behind the result
            @(posedge rst);
            key_code <= key_code_t'(CODE_UNUSED);
            key_req  <= 1'b1;
        end
        do @(negedge rst); while (!result_req);
        for (int i = 0; i < `CALC_TEXT_LEN; i++)
            assert (result_char[i] == expected[i])
            else
            begin
                value_errors++;
                $display("FAILED at %0t: char %0d is %h, expected %h (line '%s', want '%s')",
                         $time, i, result_char[i], expected[i], result_char, expected);
            end
        snap = result_char;
        repeat (ack_delay)
        begin
            @(negedge rst);
            assert (result_req && result_char == snap)
            else
            begin
                protocol_errors++;
                $display("result line changed or request dropped before ack at %0t", $time);
            end
            assert (!key_ack)
            else
            begin
                protocol_errors++;
                $display("key acknowledged while the result was pending at %0t", $time);
            end
        end
        @(posedge rst);
        result_ack <= 1'b1;
        do @(negedge rst); while (result_req);
        @(posedge rst);
        result_ack <= 1'b0;
        if (ack_delay > 0)
        begin
            do @(negedge rst); while (!key_ack);
            @(posedge rst);
            key_req <= 1'b0;
            do @(negedge rst); while (key_ack);
        end
    endtask

    // right-aligned literal against the held line
    task automatic check_text(input string s);
        logic [7:0] want;
        for (int i = 0; i < `CALC_TEXT_LEN; i++)
        begin
            want = (i < s.len()) ? s[s.len() - 1 - i] : 8'h20;
            assert (result_char[i] == want)
            else
            begin
                value_errors++;
                $display("FAILED at %0t: line '%s' does not read '%s'", $time, result_char, s);
            end
        end
    endtask

    task automatic run_case(input int n_ops, input longint unsigned v0, input longint unsigned v1,
                            input longint unsigned v2, input longint unsigned v3,
                            input int o0, input int o1, input int o2);
        expr_n_ops  = n_ops;
        expr_val[0] = v0;
        expr_val[1] = v1;
        expr_val[2] = v2;
        expr_val[3] = v3;
        expr_op[0]  = o0;
        expr_op[1]  = o1;
        expr_op[2]  = o2;
        enter_expression();
        expect_result(format_line(eval_model()), 0);
    endtask

    task automatic test_reset();
        @(negedge rst);
        assert (!key_ack && !result_req)
        else
        begin
            protocol_errors++;
            $display("handshake outputs not low after reset");
        end
        check_text("");
    endtask

    task automatic test_single_operands();
        run_case(0, 7, 0, 0, 0, 0, 0, 0);
        check_text("7");
        run_case(0, 1234, 0, 0, 0, 0, 0, 0);
        run_case(0, 0, 0, 0, 0, 0, 0, 0);
        check_text("0");
        run_case(0, 64'd4294967295, 0, 0, 0, 0, 0, 0);
        check_text("-1");
    endtask

    task automatic test_precedence();
        run_case(2, 2, 3, 4, 0, OPC_ADD, OPC_MUL, 0);
        check_text("14");
        run_case(3, 9, 2, 3, 1, OPC_SUB, OPC_MUL, OPC_SUB);
        check_text("2");
        run_case(2, 8, 3, 2, 0, OPC_SUB, OPC_SUB, 0);  // left grouping
        check_text("3");
    endtask

    task automatic test_negative();
        run_case(1, 3, 10, 0, 0, OPC_SUB, 0, 0);
        check_text("-7");
    endtask

    task automatic test_wrapping();
        run_case(1, 65536, 65536, 0, 0, OPC_MUL, 0, 0);
        check_text("0");
        run_case(1, 99999, 99999, 0, 0, OPC_MUL, 0, 0);
    endtask

    task automatic test_random();
        int delay;
        for (int k = 0; k < NUM_RANDOM; k++)
        begin
            rng = xorshift(rng);
            expr_n_ops = rng % 5;
            for (int i = 0; i <= expr_n_ops; i++)
            begin
                rng = xorshift(rng);
                expr_val[i] = rng % 1000;
            end
            for (int i = 0; i < expr_n_ops; i++)
            begin
                rng = xorshift(rng);
                expr_op[i] = rng % 3;
            end
            rng   = xorshift(rng);
            delay = rng % 12;
            enter_expression();
            expect_result(format_line(eval_model()), delay);
        end
    endtask

    initial
    begin
        rng             = 32'd88590;
        cycles          = 0;
        value_errors    = 0;
        protocol_errors = 0;
        clk_100hz       = 1'b1;
        key_req         = 1'b0;
        key_code        = KEY_0;
        result_ack      = 1'b0;
        repeat (5) @(posedge rst);
        clk_100hz <= 1'b0;

        test_reset();
        test_single_operands();
        test_precedence();
        test_negative();
        test_wrapping();
        test_random();

        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== calculator_top.f ====
+incdir+source
source/calc_pkg.sv
source/bcd_digit.sv
source/calc_stack.sv
source/key_entry.sv
source/infix_to_postfix.sv
source/postfix_eval.sv
source/bcd_convert.sv
source/result_format.sv
source/calculator_top.sv
bench/tb_calculator.sv

// ==== source/bcd_convert.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module bcd_convert import calc_pkg::*; (
    input  logic                        rst,
    input  logic                        clk_100hz,
    input  logic                        val_req,
    input  calc_word_t                  val_data,
    output logic                        val_ack,
    output logic                        bcd_valid,
    output logic                        neg,
    output bcd_t [`CALC_BCD_DIGITS-1:0] digit_vec
);

    localparam int W = `CALC_WORD_W;
    localparam int D = `CALC_BCD_DIGITS;

    typedef enum logic [1:0] {S_IDLE, S_SHIFT, S_ACK} state_t;

    state_t               state;
    logic [W-1:0]         mag;
    logic [$clog2(W)-1:0] cnt;
    logic                 start;
    logic                 shift_en;
    logic [D:0]           carry;

    assign start    = (state == S_IDLE) && val_req;
    assign shift_en = (state == S_SHIFT);
    assign carry[0] = mag[W-1];  // magnitude enters msb first

    for (genvar i = 0; i < D; i++)
    begin : g_digit
        bcd_digit u_digit (
            .rst       (rst),
            .clk_100hz (clk_100hz),
            .clear     (start),
            .shift_en  (shift_en),
            .shift_in  (carry[i]),
            .shift_out (carry[i+1]),
            .digit     (digit_vec[i])
        );
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            state     <= S_IDLE;
            cnt       <= '0;
            val_ack   <= 1'b0;
            bcd_valid <= 1'b0;
            neg       <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (start)
                    begin
                        neg   <= val_data[W-1];
                        cnt   <= '0;
                        state <= S_SHIFT;
                    end
                S_SHIFT:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == W - 1)
                    begin
                        val_ack   <= 1'b1;
                        bcd_valid <= 1'b1;
                        state     <= S_ACK;
                    end
                end
                default:
                begin
                    bcd_valid <= 1'b0;  // single pulse
                    if (!val_req)
                    begin
                        val_ack <= 1'b0;
                        state   <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge rst)
    begin
        if (start)
            mag <= val_data[W-1] ? -val_data : val_data;
        else if (shift_en)
            mag <= {mag[W-2:0], 1'b0};
    end

endmodule

// ==== source/bcd_digit.sv ====
`timescale 1ns/1ps

module bcd_digit (
    input  logic       rst,
    input  logic       clk_100hz,
    input  logic       clear,
    input  logic       shift_en,
    input  logic       shift_in,
    output logic       shift_out,
    output logic [3:0] digit
);

    logic [3:0] adj;

    assign adj       = (digit >= 4'd5) ? digit + 4'd3 : digit;  // add-3 before shift
    assign shift_out = adj[3];

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
            digit <= 4'd0;
        else if (clear)
            digit <= 4'd0;
        else if (shift_en)
            digit <= {adj[2:0], shift_in};
    end

endmodule

// ==== source/calc_params.svh ====
`ifndef CALC_PARAMS_SVH
`define CALC_PARAMS_SVH

// two's complement datapath width
`define CALC_WORD_W      32
`define CALC_STACK_DEPTH 8

// ten digits hold 2^31
`define CALC_BCD_DIGITS  10
`define CALC_TEXT_LEN    11  // digits plus sign

`endif

// ==== source/calc_pkg.sv ====
`include "calc_params.svh"

package calc_pkg;

    // codes 14 and 15 are not assigned
    typedef enum logic [3:0] {
        KEY_0   = 4'd0,
        KEY_1   = 4'd1,
        KEY_2   = 4'd2,
        KEY_3   = 4'd3,
        KEY_4   = 4'd4,
        KEY_5   = 4'd5,
        KEY_6   = 4'd6,
        KEY_7   = 4'd7,
        KEY_8   = 4'd8,
        KEY_9   = 4'd9,
        KEY_ADD = 4'd10,
        KEY_SUB = 4'd11,
        KEY_MUL = 4'd12,
        KEY_EQU = 4'd13
    } key_code_t;

    typedef enum logic [1:0] {OP_ADD, OP_SUB, OP_MUL, OP_END} op_t;

    typedef logic signed [`CALC_WORD_W-1:0] calc_word_t;

    typedef struct packed {
        logic       is_op;
        op_t        op;     // valid when is_op
        calc_word_t value;  // valid when !is_op
    } token_t;

    typedef logic [3:0] bcd_t;

    localparam logic [7:0] ASCII_BLANK = 8'h20;
    localparam logic [7:0] ASCII_ZERO  = 8'h30;
    localparam logic [7:0] ASCII_MINUS = 8'h2d;

endpackage

// ==== source/calc_stack.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module calc_stack import calc_pkg::*; #(
    parameter type T = calc_word_t
) (
    input  logic rst,
    input  logic clk_100hz,
    input  logic push,
    input  logic pop,
    input  T     push_data,
    output T     top,
    output T     next,
    output logic empty,
    output logic full
);

    localparam int AW = $clog2(`CALC_STACK_DEPTH);

    T              mem [`CALC_STACK_DEPTH];
    logic [AW:0]   count;
    logic [AW-1:0] top_idx;
    logic          do_push;
    logic          do_pop;

    assign empty   = (count == '0);
    assign full    = (count == `CALC_STACK_DEPTH);
    assign top_idx = AW'(count - 1'b1);
    assign top     = mem[top_idx];
    assign next    = mem[AW'(count - 2'd2)];  // meaningful with two entries
    assign do_pop  = pop && !empty;
    assign do_push = push && (do_pop || !full);  // push+pop overwrites top

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
            count <= '0;
        else if (do_push && !do_pop)
            count <= count + 1'b1;
        else if (do_pop && !do_push)
            count <= count - 1'b1;
    end

    always_ff @(posedge rst)
    begin
        if (do_push)
            mem[do_pop ? top_idx : count[AW-1:0]] <= push_data;
    end

endmodule

// ==== source/calculator_top.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module calculator_top import calc_pkg::*; (
    input  logic                           rst,
    input  logic                           clk_100hz,
    input  logic                           key_req,
    input  key_code_t                      key_code,
    output logic                           key_ack,
    output logic                           result_req,
    input  logic                           result_ack,
    output logic [`CALC_TEXT_LEN-1:0][7:0] result_char
);

    logic                        calc_done;
    logic                        tok_valid;
    token_t                      tok;
    logic                        tok_ready;
    logic                        pf_valid;
    token_t                      pf_tok;
    logic                        pf_ready;
    logic                        val_req;
    calc_word_t                  val_data;
    logic                        val_ack;
    logic                        bcd_valid;
    logic                        neg;
    bcd_t [`CALC_BCD_DIGITS-1:0] digit_vec;

    key_entry u_key_entry (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .key_req   (key_req),
        .key_code  (key_code),
        .key_ack   (key_ack),
        .calc_done (calc_done),
        .tok_valid (tok_valid),
        .tok       (tok),
        .tok_ready (tok_ready)
    );

    infix_to_postfix u_infix_to_postfix (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .tok_valid (tok_valid),
        .tok       (tok),
        .tok_ready (tok_ready),
        .pf_valid  (pf_valid),
        .pf_tok    (pf_tok),
        .pf_ready  (pf_ready)
    );

    postfix_eval u_postfix_eval (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .pf_valid  (pf_valid),
        .pf_tok    (pf_tok),
        .pf_ready  (pf_ready),
        .val_req   (val_req),
        .val_data  (val_data),
        .val_ack   (val_ack)
    );

    bcd_convert u_bcd_convert (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .val_req   (val_req),
        .val_data  (val_data),
        .val_ack   (val_ack),
        .bcd_valid (bcd_valid),
        .neg       (neg),
        .digit_vec (digit_vec)
    );

    result_format u_result_format (
        .rst         (rst),
        .clk_100hz   (clk_100hz),
        .bcd_valid   (bcd_valid),
        .neg         (neg),
        .digit_vec   (digit_vec),
        .result_req  (result_req),
        .result_ack  (result_ack),
        .result_char (result_char),
        .calc_done   (calc_done)
    );

endmodule

// ==== source/infix_to_postfix.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module infix_to_postfix import calc_pkg::*; (
    input  logic   rst,
    input  logic   clk_100hz,
    input  logic   tok_valid,
    input  token_t tok,
    output logic   tok_ready,
    output logic   pf_valid,
    output token_t pf_tok,
    input  logic   pf_ready
);

    logic   out_free;
    logic   emit;
    logic   op_push;
    logic   op_pop;
    logic   op_empty;
    op_t    op_top;
    token_t emit_tok;

    function automatic logic prec(op_t op);
        return (op == OP_MUL);
    endfunction

    calc_stack #(.T(op_t)) u_op_stack (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .push      (op_push),
        .pop       (op_pop),
        .push_data (tok.op),
        .top       (op_top),
        .next      (),
        .empty     (op_empty),
        .full      ()
    );

    assign out_free = !pf_valid || pf_ready;

    // each cycle passes an operand, pops an operator or pushes one
    always_comb
    begin
        tok_ready = 1'b0;
        op_push   = 1'b0;
        op_pop    = 1'b0;
        emit      = 1'b0;
        emit_tok  = tok;
        if (tok_valid)
        begin
            if (!tok.is_op)
            begin
                emit      = out_free;
                tok_ready = out_free;
            end
            else if (!op_empty && (tok.op == OP_END || prec(op_top) >= prec(tok.op)))
            begin
                op_pop   = out_free;
                emit     = out_free;
                emit_tok = '{is_op: 1'b1, op: op_top, value: '0};
            end
            else if (tok.op == OP_END)
            begin
                emit      = out_free;  // END goes out once the stack is drained
                tok_ready = out_free;
            end
            else
            begin
                op_push   = 1'b1;
                tok_ready = 1'b1;
            end
        end
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
            pf_valid <= 1'b0;
        else if (emit)
            pf_valid <= 1'b1;
        else if (pf_ready)
            pf_valid <= 1'b0;
    end

    always_ff @(posedge rst)
    begin
        if (emit)
            pf_tok <= emit_tok;
    end

endmodule

// ==== source/key_entry.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module key_entry import calc_pkg::*; (
    input  logic      rst,
    input  logic      clk_100hz,
    input  logic      key_req,
    input  key_code_t key_code,
    output logic      key_ack,
    input  logic      calc_done,
    output logic      tok_valid,
    output token_t    tok,
    input  logic      tok_ready
);

    typedef enum logic [1:0] {S_IDLE, S_NUM, S_OP, S_WAIT} state_t;

    state_t     state;
    calc_word_t operand;  // stays zero if no digit was typed
    op_t        pend_op;
    logic       accept;

    assign accept    = key_req && !key_ack && (state == S_IDLE);
    assign tok_valid = (state == S_NUM) || (state == S_OP);
    assign tok       = '{is_op: (state == S_OP), op: pend_op, value: operand};

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            state   <= S_IDLE;
            key_ack <= 1'b0;
            operand <= '0;
            pend_op <= OP_ADD;
        end
        else
        begin
            if (accept)
                key_ack <= 1'b1;
            else if (!key_req)
                key_ack <= 1'b0;

            case (state)
                S_IDLE:
                    if (accept)
                    begin
                        if (key_code <= KEY_9)
                            operand <= operand * 10 + {{(`CALC_WORD_W-4){1'b0}}, key_code};
                        else if (key_code <= KEY_EQU)
                        begin
                            case (key_code)
                                KEY_ADD: pend_op <= OP_ADD;
                                KEY_SUB: pend_op <= OP_SUB;
                                KEY_MUL: pend_op <= OP_MUL;
                                default: pend_op <= OP_END;
                            endcase
                            state <= S_NUM;  // operand goes out first
                        end
                    end
                S_NUM:
                    if (tok_ready)
                    begin
                        operand <= '0;
                        state   <= S_OP;
                    end
                S_OP:
                    if (tok_ready)
                        state <= (pend_op == OP_END) ? S_WAIT : S_IDLE;
                default:
                    if (calc_done)
                        state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== source/postfix_eval.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module postfix_eval import calc_pkg::*; (
    input  logic       rst,
    input  logic       clk_100hz,
    input  logic       pf_valid,
    input  token_t     pf_tok,
    output logic       pf_ready,
    output logic       val_req,
    output calc_word_t val_data,
    input  logic       val_ack
);

    typedef enum logic [1:0] {S_RUN, S_REQ, S_REL} state_t;

    state_t     state;
    calc_word_t acc;  // logical top of the value stack
    calc_word_t lhs;
    logic       acc_valid;
    logic       v_push;
    logic       v_pop;
    logic       v_empty;

    function automatic calc_word_t apply(op_t op, calc_word_t a, calc_word_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            default: return a * b;  // wraps at word width
        endcase
    endfunction

    calc_stack #(.T(calc_word_t)) u_val_stack (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .push      (v_push),
        .pop       (v_pop),
        .push_data (acc),
        .top       (lhs),
        .next      (),
        .empty     (v_empty),
        .full      ()
    );

    assign pf_ready = (state == S_RUN);
    assign val_data = acc;
    assign v_push   = pf_ready && pf_valid && !pf_tok.is_op && acc_valid;
    // outside RUN any leftovers are drained
    assign v_pop    = pf_ready ? (pf_valid && pf_tok.is_op && pf_tok.op != OP_END) : !v_empty;

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            state     <= S_RUN;
            acc_valid <= 1'b0;
            val_req   <= 1'b0;
        end
        else
        begin
            case (state)
                S_RUN:
                    if (pf_valid && !pf_tok.is_op)
                        acc_valid <= 1'b1;
                    else if (pf_valid && pf_tok.op == OP_END)
                    begin
                        acc_valid <= 1'b0;
                        val_req   <= 1'b1;
                        state     <= S_REQ;
                    end
                S_REQ:
                    if (val_ack)
                    begin
                        val_req <= 1'b0;
                        state   <= S_REL;
                    end
                default:
                    if (!val_ack)
                        state <= S_RUN;
            endcase
        end
    end

    always_ff @(posedge rst)
    begin
        if (pf_ready && pf_valid && !pf_tok.is_op)
            acc <= pf_tok.value;
        else if (pf_ready && pf_valid && pf_tok.op != OP_END)
            acc <= apply(pf_tok.op, lhs, acc);
    end

endmodule

// ==== source/result_format.sv ====
`timescale 1ns/1ps
`include "calc_params.svh"

module result_format import calc_pkg::*; (
    input  logic                             rst,
    input  logic                             clk_100hz,
    input  logic                             bcd_valid,
    input  logic                             neg,
    input  bcd_t [`CALC_BCD_DIGITS-1:0]      digit_vec,
    output logic                             result_req,
    input  logic                             result_ack,
    output logic [`CALC_TEXT_LEN-1:0][7:0]   result_char,
    output logic                             calc_done
);

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_REL} state_t;

    state_t                         state;
    logic [`CALC_TEXT_LEN-1:0][7:0] line;

    always_comb
    begin
        int msd;
        line = {`CALC_TEXT_LEN{ASCII_BLANK}};
        msd  = 0;  // a zero result keeps one digit
        for (int i = 1; i < `CALC_BCD_DIGITS; i++)
            if (digit_vec[i] != 4'd0)
                msd = i;
        for (int i = 0; i < `CALC_BCD_DIGITS; i++)
            if (i <= msd)
                line[i] = ASCII_ZERO + 8'(digit_vec[i]);
        if (neg)
            line[msd + 1] = ASCII_MINUS;
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            state       <= S_IDLE;
            result_req  <= 1'b0;
            calc_done   <= 1'b0;
            result_char <= {`CALC_TEXT_LEN{ASCII_BLANK}};
        end
        else
        begin
            calc_done <= 1'b0;
            case (state)
                S_IDLE:
                    if (bcd_valid)
                    begin
                        result_char <= line;  // held until the next result
                        result_req  <= 1'b1;
                        state       <= S_REQ;
                    end
                S_REQ:
                    if (result_ack)
                    begin
                        result_req <= 1'b0;
                        state      <= S_REL;
                    end
                default:
                    if (!result_ack)
                    begin
                        calc_done <= 1'b1;
                        state     <= S_IDLE;
                    end
            endcase
        end
    end

endmodule
